//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_icache
FLIST     = flist.f
BUILD     = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	@out=$$(./$(BUILD)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(BUILD)

//--- common/icache_if.sv
`default_nettype none

// tag lookup and tag update between ctrl and the tag store
interface meta_port_if import icache_pkg::*; ();

    index_t raddr1;
    index_t raddr2;
    logic we;
    index_t waddr;
    way_t wway;
    tag_t wtag;

    // one entry per way for each read port
    logic [num_ways-1:0] rvalid1;
    tag_t [num_ways-1:0] rtag1;
    logic [num_ways-1:0] rvalid2;
    tag_t [num_ways-1:0] rtag2;

    modport master (
        output raddr1, raddr2, we, waddr, wway, wtag,
        input  rvalid1, rtag1, rvalid2, rtag2
    );

    modport slave (
        input  raddr1, raddr2, we, waddr, wway, wtag,
        output rvalid1, rtag1, rvalid2, rtag2
    );

endinterface

// one port of the data array, read data one cycle after en
interface data_port_if import icache_pkg::*; ();

    logic en;
    strobe_t strobe;
    data_addr_t addr;
    word_t wdata;
    word_t rdata;

    modport master (output en, strobe, addr, wdata, input rdata);

    modport slave (input en, strobe, addr, wdata, output rdata);

endinterface

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int line_words = 16;
    localparam int num_sets = 128;
    localparam int num_ways = 2;

    localparam int word_bytes = 4;
    localparam int align_bits = $clog2(word_bytes);
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(num_sets);
    localparam int way_bits = $clog2(num_ways);
    localparam int tag_bits = 32 - index_bits - offset_bits - align_bits;

    // way, index and offset side by side
    localparam int data_addr_bits = way_bits + index_bits + offset_bits;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0] way_t;
    typedef logic [data_addr_bits-1:0] data_addr_t;
    typedef logic [word_bytes-1:0] strobe_t;

    // address field split
    function automatic tag_t addr_tag(addr_t addr);
        return addr[31 -: tag_bits];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[align_bits + offset_bits +: index_bits];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[align_bits +: offset_bits];
    endfunction

    function automatic data_addr_t data_addr(way_t way, index_t index, offset_t offset);
        return {way, index, offset};
    endfunction

    function automatic index_t data_addr_index(data_addr_t daddr);
        return daddr[offset_bits +: index_bits];
    endfunction

    function automatic way_t data_addr_way(data_addr_t daddr);
        return daddr[data_addr_bits-1 -: way_bits];
    endfunction

endpackage

`default_nettype wire

//--- flist.f
common/icache_pkg.sv
common/icache_if.sv
icache/icache_meta_ram.sv
icache/icache_data_ram.sv
icache/icache_plru.sv
icache/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_chk.sv
testbench/tb_icache.sv

//--- hdl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req1_valid,
    input  addr_t       req1_addr,
    input  logic        req2_valid,
    input  addr_t       req2_addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [63:0] rdata,
    output logic        mem_valid,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  logic        mem_last,
    input  word_t       mem_data
);

    index_t index1, index2;
    logic hit_upd1, hit_upd2;
    way_t hit_way1, hit_way2;
    way_t victim1, victim2;

    meta_port_if meta_bus ();
    data_port_if port_a_bus ();
    data_port_if port_b_bus ();

    icache_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .req1_valid (req1_valid),
        .req1_addr  (req1_addr),
        .req2_valid (req2_valid),
        .req2_addr  (req2_addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_last   (mem_last),
        .mem_data   (mem_data),
        .meta       (meta_bus.master),
        .port_a     (port_a_bus.master),
        .port_b     (port_b_bus.master),
        .index1     (index1),
        .index2     (index2),
        .hit_upd1   (hit_upd1),
        .hit_upd2   (hit_upd2),
        .hit_way1   (hit_way1),
        .hit_way2   (hit_way2),
        .victim1    (victim1),
        .victim2    (victim2)
    );

    icache_meta_ram #(
        .set_count (num_sets),
        .tag_width (tag_bits)
    ) u_meta_ram (
        .clk    (clk),
        .resetn (resetn),
        .meta   (meta_bus.slave)
    );

    // 2 ways x 128 sets x 16 words
    icache_data_ram #(
        .addr_width (data_addr_bits),
        .data_width ($bits(word_t))
    ) u_data_ram (
        .clk    (clk),
        .port_a (port_a_bus.slave),
        .port_b (port_b_bus.slave)
    );

    icache_plru u_plru (
        .clk      (clk),
        .resetn   (resetn),
        .index1   (index1),
        .index2   (index2),
        .hit_upd1 (hit_upd1),
        .hit_upd2 (hit_upd2),
        .hit_way1 (hit_way1),
        .hit_way2 (hit_way2),
        .victim1  (victim1),
        .victim2  (victim2)
    );

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req1_valid,
    input  addr_t       req1_addr,
    input  logic        req2_valid,
    input  addr_t       req2_addr,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t [1:0] rdata,
    output logic        mem_valid,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  logic        mem_last,
    input  word_t       mem_data,
    meta_port_if.master meta,
    data_port_if.master port_a,
    data_port_if.master port_b,
    output index_t      index1,
    output index_t      index2,
    output logic        hit_upd1,
    output logic        hit_upd2,
    output way_t        hit_way1,
    output way_t        hit_way2,
    input  way_t        victim1,
    input  way_t        victim2
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH_1,
        FETCH_2
    } state_t;

    state_t state;
    tag_t tag1, tag2;
    offset_t offset1, offset2;
    logic [num_ways-1:0] hit_bits1, hit_bits2;
    logic hit1, hit2;
    logic miss1, miss2;
    data_addr_t refill_q;
    logic data_ok_q;

    assign tag1 = addr_tag(req1_addr);
    assign tag2 = addr_tag(req2_addr);
    assign index1 = addr_index(req1_addr);
    assign index2 = addr_index(req2_addr);
    assign offset1 = addr_offset(req1_addr);
    assign offset2 = addr_offset(req2_addr);

    assign meta.raddr1 = index1;
    assign meta.raddr2 = index2;

    // per-way tag compare
    always_comb begin
        hit_way1 = '0;
        hit_way2 = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_bits1[w] = meta.rvalid1[w] && (meta.rtag1[w] == tag1);
            hit_bits2[w] = meta.rvalid2[w] && (meta.rtag2[w] == tag2);
            if (hit_bits1[w]) begin
                hit_way1 = way_t'(w);
            end
            if (hit_bits2[w]) begin
                hit_way2 = way_t'(w);
            end
        end
    end

    assign hit1 = |hit_bits1;
    assign hit2 = |hit_bits2;

    assign hit_upd1 = (state == IDLE) && req1_valid && hit1;
    assign hit_upd2 = (state == IDLE) && req2_valid && hit2;
    assign addr_ok = hit_upd1 && hit_upd2;

    // request 1 first, request 2 only behind a hit on request 1
    assign miss1 = req1_valid && !hit1;
    assign miss2 = req1_valid && hit1 && req2_valid && !hit2;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= addr_ok;
            case (state)
                IDLE: begin
                    if (miss1) begin
                        state <= FETCH_1;
                    end else if (miss2) begin
                        state <= FETCH_2;
                    end
                end
                FETCH_1, FETCH_2: begin
                    if (mem_ready && mem_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // refill target, offset wraps inside the line
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (miss1) begin
                refill_q <= data_addr(victim1, index1, offset1);
            end else if (miss2) begin
                refill_q <= data_addr(victim2, index2, offset2);
            end
        end else if (mem_ready) begin
            refill_q[offset_bits-1:0] <= refill_q[offset_bits-1:0] + 1'b1;
        end
    end

    // tag goes valid with the last beat
    assign meta.we = (state != IDLE) && mem_ready && mem_last;
    assign meta.waddr = data_addr_index(refill_q);
    assign meta.wway = data_addr_way(refill_q);
    assign meta.wtag = (state == FETCH_2) ? tag2 : tag1;

    assign mem_valid = (state != IDLE);

    always_comb begin
        case (state)
            FETCH_1: mem_addr = req1_addr;
            FETCH_2: mem_addr = req2_addr;
            default: mem_addr = '0;
        endcase
    end

    // port_a reads request 1
    assign port_a.en = addr_ok;
    assign port_a.strobe = '0;
    assign port_a.addr = data_addr(hit_way1, index1, offset1);
    assign port_a.wdata = '0;

    // port_b reads request 2 or takes refill beats
    always_comb begin
        port_b.en = addr_ok;
        port_b.strobe = '0;
        port_b.addr = data_addr(hit_way2, index2, offset2);
        port_b.wdata = '0;
        if (state != IDLE) begin
            port_b.en = mem_ready;
            port_b.strobe = '1;
            port_b.addr = refill_q;
            port_b.wdata = mem_data;
        end
    end

    assign data_ok = data_ok_q;
    assign rdata = {port_b.rdata, port_a.rdata};

endmodule

`default_nettype wire

//--- icache/icache_data_ram.sv
`default_nettype none

module icache_data_ram #(
    parameter int addr_width = 12,
    parameter int data_width = 32
) (
    input logic clk,
    data_port_if.slave port_a,
    data_port_if.slave port_b
);

    localparam int byte_count = data_width / 8;
    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // port_b is applied last, so it wins on a same-address write
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            for (int b = 0; b < byte_count; b++) begin
                if (port_a.strobe[b]) begin
                    mem[port_a.addr][b*8 +: 8] <= port_a.wdata[b*8 +: 8];
                end
            end
            port_a.rdata <= mem[port_a.addr];
        end
        if (port_b.en) begin
            for (int b = 0; b < byte_count; b++) begin
                if (port_b.strobe[b]) begin
                    mem[port_b.addr][b*8 +: 8] <= port_b.wdata[b*8 +: 8];
                end
            end
            port_b.rdata <= mem[port_b.addr];
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_meta_ram.sv
`default_nettype none

module icache_meta_ram import icache_pkg::*; #(
    parameter int set_count = 128,
    parameter int tag_width = 21
) (
    input logic clk,
    input logic resetn,
    meta_port_if.slave meta
);

    logic [tag_width-1:0] tags [num_ways][set_count];
    logic [num_ways-1:0][set_count-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (meta.we) begin
            tags[meta.wway][meta.waddr] <= meta.wtag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
        end else if (meta.we) begin
            valid_q[meta.wway][meta.waddr] <= 1'b1;
        end
    end

    // both read ports are asynchronous
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            meta.rvalid1[w] = valid_q[w][meta.raddr1];
            meta.rtag1[w] = tags[w][meta.raddr1];
            meta.rvalid2[w] = valid_q[w][meta.raddr2];
            meta.rtag2[w] = tags[w][meta.raddr2];
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_plru.sv
`default_nettype none

module icache_plru import icache_pkg::*; (
    input  logic   clk,
    input  logic   resetn,
    input  index_t index1,
    input  index_t index2,
    input  logic   hit_upd1,
    input  logic   hit_upd2,
    input  way_t   hit_way1,
    input  way_t   hit_way2,
    output way_t   victim1,
    output way_t   victim2
);

    // one bit per set, names the way to replace next
    logic [num_sets-1:0] repl_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            repl_q <= '0;
        end else begin
            if (hit_upd1) begin
                repl_q[index1] <= ~hit_way1;
            end
            // second update overrides the first on a shared set
            if (hit_upd2) begin
                repl_q[index2] <= ~hit_way2;
            end
        end
    end

    assign victim1 = repl_q[index1];

    // same set as request 1: avoid the way request 1 is using
    always_comb begin
        if (index1 == index2) begin
            victim2 = ~hit_way1;
        end else begin
            victim2 = repl_q[index2];
        end
    end

endmodule

`default_nettype wire

//--- testbench/icache_chk.sv
`default_nettype none

module icache_chk import icache_pkg::*; (
    input logic  clk,
    input logic  resetn,
    input logic  addr_ok,
    input logic  data_ok,
    input logic  mem_valid,
    input addr_t mem_addr,
    input logic  mem_ready,
    input logic  mem_last
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // response exactly one cycle after acceptance
    assert property (@(posedge clk) disable iff (resetn) addr_ok |=> data_ok)
        else begin
            failures++;
            $error("data_ok missing after addr_ok");
        end

    assert property (@(posedge clk) disable iff (resetn) data_ok |-> $past(addr_ok))
        else begin
            failures++;
            $error("data_ok without addr_ok");
        end

    // burst holds until the last beat
    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> mem_valid)
        else begin
            failures++;
            $error("mem_valid dropped before the last beat");
        end

    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> $stable(mem_addr))
        else begin
            failures++;
            $error("mem_addr changed during a burst");
        end

    assert property (@(posedge clk) disable iff (resetn) !(addr_ok && mem_valid))
        else begin
            failures++;
            $error("addr_ok during a refill");
        end

endmodule

bind icache_ctrl icache_chk u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .mem_last  (mem_last)
);

`default_nettype wire

//--- testbench/icache_vectors.txt
// test (hex), addr1, addr2, expected word1, expected word2, refill1, refill2
// expected word is the complement of its address; refill flag 1 means one burst
01 00001040 00002084 ffffefbf ffffdf7b 1 1
02 00001044 000030bc ffffefbb ffffcf43 0 1
03 00002088 00004100 ffffdf77 ffffbeff 0 1
04 00010280 00020284 fffefd7f fffdfd7b 1 1
05 00010280 00020284 fffefd7f fffdfd7b 0 0
06 00010288 00001048 fffefd77 ffffefb7 0 0
07 00030290 0000104c fffcfd6f ffffefb3 1 0
08 00010280 00001050 fffefd7f ffffefaf 0 0
09 00020284 00001054 fffdfd7b ffffefab 1 0
0a 00030290 00001058 fffcfd6f ffffefa7 1 0
0b 00041380 000413a4 fffbec7f fffbec5b 1 0
0c 000507fc 00060a7c fffaf803 fff9f583 1 1
0d 00030290 00010280 fffcfd6f fffefd7f 0 1
0e 00030290 00010280 fffcfd6f fffefd7f 0 0
0f 00020284 0000105c fffdfd7b ffffefa3 1 0

//--- testbench/tb_icache.sv
`default_nettype none

module tb_icache import icache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int vec_count = 15;
    localparam int vec_fields = 7;
    // up to three idle cycles before each beat
    localparam int max_gap = 4;
    localparam int cycle_limit = vec_count * (16 * max_gap + 8) * 2 + 4;

    logic clk;
    logic resetn;
    logic req1_valid;
    logic req2_valid;
    addr_t req1_addr;
    addr_t req2_addr;
    logic addr_ok;
    logic data_ok;
    logic [63:0] rdata;
    logic mem_valid;
    addr_t mem_addr;
    logic mem_ready;
    logic mem_last;
    word_t mem_data;

    logic [31:0] vectors [vec_count * vec_fields];
    logic [15:0] lfsr;
    int cycle_count = 0;
    int errors = 0;
    int tests_failed = 0;

    // memory model state
    logic burst_active;
    int beat;
    int gap;
    addr_t burst_addr;

    // pair under test and the refills seen for it
    addr_t cur_a1;
    addr_t cur_a2;
    logic exp_f1;
    logic exp_f2;
    logic got1;
    logic got2;

    icache_top DUT (
        .clk        (clk),
        .resetn     (resetn),
        .req1_valid (req1_valid),
        .req1_addr  (req1_addr),
        .req2_valid (req2_valid),
        .req2_addr  (req2_addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_last   (mem_last),
        .mem_data   (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(negedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout: no response from the cache within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_gap();
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // memory word at byte address A is ~A
    // bursts wrap inside the line
    task automatic drive_memory();
        logic [3:0] word;
        addr_t word_addr;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        if (burst_active && gap > 0) begin
            gap--;
        end else if (burst_active) begin
            word = burst_addr[5:2] + beat[3:0];
            word_addr = {burst_addr[31:6], word, 2'b00};
            mem_ready = 1'b1;
            mem_last = (beat == 15);
            mem_data = ~word_addr;
        end
    endtask

    task automatic sample_memory();
        if (mem_valid && !burst_active) begin
            burst_active = 1'b1;
            beat = 0;
            burst_addr = mem_addr;
            draw_gap();
            if (exp_f1 && !got1) begin
                check_addr("mem_addr", mem_addr, cur_a1);
            end else if (exp_f2 && !got2) begin
                check_addr("mem_addr", mem_addr, cur_a2);
            end else begin
                errors++;
                $display("unexpected refill burst for address %h at %0d ns", mem_addr, $time);
            end
            if (mem_addr == cur_a1) begin
                got1 = 1'b1;
            end else if (mem_addr == cur_a2) begin
                got2 = 1'b1;
            end
        end else if (mem_valid && mem_ready) begin
            if (mem_last) begin
                burst_active = 1'b0;
            end else begin
                beat++;
                draw_gap();
            end
        end
    endtask

    task automatic next_cycle(input logic valid, input addr_t a1, input addr_t a2);
        @(posedge clk);
        #2;
        req1_valid = valid;
        req2_valid = valid;
        req1_addr = a1;
        req2_addr = a2;
        drive_memory();
        @(negedge clk);
        sample_memory();
    endtask

    task automatic run_test(input int v);
        int base;
        int errors_before;
        logic accepted;
        base = v * vec_fields;
        cur_a1 = vectors[base + 1];
        cur_a2 = vectors[base + 2];
        exp_f1 = vectors[base + 5][0];
        exp_f2 = vectors[base + 6][0];
        got1 = 1'b0;
        got2 = 1'b0;
        errors_before = errors;
        accepted = 1'b0;
        while (!accepted) begin
            next_cycle(1'b1, cur_a1, cur_a2);
            check_flag("data_ok", data_ok, 1'b0);
            accepted = addr_ok;
        end
        next_cycle(1'b0, '0, '0);
        check_flag("data_ok", data_ok, 1'b1);
        check_word("rdata[31:0]", rdata[31:0], vectors[base + 3]);
        check_word("rdata[63:32]", rdata[63:32], vectors[base + 4]);
        check_flag("refill1", got1, exp_f1);
        check_flag("refill2", got2, exp_f2);
        if (errors == errors_before) begin
            $display("test %0d passed", vectors[base]);
        end else begin
            tests_failed++;
            $display("test %0d failed", vectors[base]);
        end
    endtask

    initial begin : stimulus
        resetn = 1'b1;
        req1_valid = 1'b0;
        req2_valid = 1'b0;
        req1_addr = '0;
        req2_addr = '0;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_data = '0;
        burst_active = 1'b0;
        beat = 0;
        gap = 0;
        lfsr = 16'd52;
        $readmemh("testbench/icache_vectors.txt", vectors);
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b0;
        @(negedge clk);
        check_flag("addr_ok", addr_ok, 1'b0);
        check_flag("data_ok", data_ok, 1'b0);
        check_flag("mem_valid", mem_valid, 1'b0);
        for (int v = 0; v < vec_count; v++) begin
            run_test(v);
        end
        errors = errors + DUT.u_ctrl.u_chk.failures;
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
            vec_count, vec_count - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
